// ==== include/bpu_cfg.svh ====
`ifndef BPU_CFG_SVH
`define BPU_CFG_SVH

`define XLEN            32
`define BTB_INDEX_BITS  6
// upper pc bits left above the index and the byte offset
`define BTB_TAG_BITS    (`XLEN - `BTB_INDEX_BITS - 2)
`define LHT_INDEX_BITS  4
`define HIST_BITS       4
`define BQ_DEPTH        8
`define RESET_PC        32'h0000_0000

`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111

`endif

// ==== design/bpu_pkg.sv ====
`include "bpu_cfg.svh"

package bpu_pkg;

  typedef enum logic [6:0]
  {
    opc_branch = `OPC_BRANCH,
    opc_jal    = `OPC_JAL,
    opc_jalr   = `OPC_JALR
  } opcode_e;

  typedef enum logic [1:0]
  {
    kind_none = 2'd0,
    kind_cond = 2'd1,
    kind_jal  = 2'd2,
    kind_jalr = 2'd3
  } ctrl_kind_e;

  // one instruction handed to decode
  typedef struct packed
  {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] inst;
    ctrl_kind_e       kind;
    logic             pred_taken;
    logic [`XLEN-1:0] pred_next;
  } issue_pkt_t;

  // outcome of the oldest recorded control instruction
  typedef struct packed
  {
    logic             taken;
    logic [`XLEN-1:0] target;
  } resolve_pkt_t;

  typedef struct packed
  {
    logic             hit;
    logic [`XLEN-1:0] target;
  } lookup_t;

  typedef struct packed
  {
    logic [`XLEN-1:0] pc;
    ctrl_kind_e       kind;
    logic             pred_taken;
    logic [`XLEN-1:0] pred_next;
  } bq_entry_t;

endpackage

// ==== design/branch_queue.sv ====
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module branch_queue
  import bpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      push,
  input  bq_entry_t entry,
  input  logic      pop,
  input  logic      clear,
  output logic      full,
  output logic      empty,
  output bq_entry_t head
);

  localparam int PTR_W = $clog2(`BQ_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  bq_entry_t        mem [`BQ_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  assign full  = (count == CNT_W'(`BQ_DEPTH));
  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else if (clear)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + PTR_W'(1);
      if (pop)
        rd_ptr <= rd_ptr + PTR_W'(1);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push && !clear)
      mem[wr_ptr] <= entry;
  end

  // issue side must respect full, execute side only resolves what was recorded
  assert property (@(posedge clk) disable iff (rst) push |-> !full);
  assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// ==== design/branch_target_buffer.sv ====
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module branch_target_buffer
  import bpu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] lookup_pc,
  output lookup_t          result,
  input  logic             upd_valid,
  input  logic [`XLEN-1:0] upd_pc,
  input  ctrl_kind_e       upd_kind,
  input  resolve_pkt_t     resolve
);

  localparam int ENTRIES = 1 << `BTB_INDEX_BITS;

  logic [ENTRIES-1:0]         vld;
  logic [`BTB_TAG_BITS-1:0]   tag_mem [ENTRIES];
  logic [`XLEN-1:0]           tgt_mem [ENTRIES];
  logic [`BTB_INDEX_BITS-1:0] rd_idx;
  logic [`BTB_TAG_BITS-1:0]   rd_tag;
  logic [`BTB_INDEX_BITS-1:0] wr_idx;
  logic [`BTB_TAG_BITS-1:0]   wr_tag;

  assign rd_idx = lookup_pc[`BTB_INDEX_BITS+1:2];  // skip byte offset
  assign rd_tag = lookup_pc[`XLEN-1:`BTB_INDEX_BITS+2];
  assign wr_idx = upd_pc[`BTB_INDEX_BITS+1:2];
  assign wr_tag = upd_pc[`XLEN-1:`BTB_INDEX_BITS+2];

  assign result.hit    = vld[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign result.target = tgt_mem[rd_idx];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      vld <= '0;
    else if (upd_valid && (upd_kind != kind_none) && resolve.taken)
      vld[wr_idx] <= 1'b1;
  end

  // not-taken outcomes leave the entry alone
  always_ff @(posedge clk)
  begin
    if (upd_valid && (upd_kind != kind_none) && resolve.taken)
    begin
      tag_mem[wr_idx] <= wr_tag;
      tgt_mem[wr_idx] <= resolve.target;
    end
  end

endmodule

// ==== design/local_history_predictor.sv ====
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module local_history_predictor
  import bpu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] lookup_pc,
  output logic             pred_taken,
  input  logic             upd_valid,
  input  logic [`XLEN-1:0] upd_pc,
  input  ctrl_kind_e       upd_kind,
  input  logic             upd_taken
);

  localparam int LHT_ENTRIES = 1 << `LHT_INDEX_BITS;
  localparam int PHT_ENTRIES = 1 << `HIST_BITS;

  logic [`HIST_BITS-1:0]      lht [LHT_ENTRIES];
  logic [1:0]                 pht [PHT_ENTRIES];
  logic [`LHT_INDEX_BITS-1:0] rd_idx;
  logic [`HIST_BITS-1:0]      rd_hist;
  logic [`LHT_INDEX_BITS-1:0] upd_idx;
  logic [`HIST_BITS-1:0]      upd_hist;
  logic [1:0]                 upd_ctr;

  assign rd_idx     = lookup_pc[`LHT_INDEX_BITS+1:2];
  assign rd_hist    = lht[rd_idx];
  assign pred_taken = pht[rd_hist][1];  // weakly or strongly taken

  assign upd_idx  = upd_pc[`LHT_INDEX_BITS+1:2];
  assign upd_hist = lht[upd_idx];
  assign upd_ctr  = pht[upd_hist];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < LHT_ENTRIES; i++)
        lht[i] <= '0;
      for (int j = 0; j < PHT_ENTRIES; j++)
        pht[j] <= 2'b00;
    end
    else if (upd_valid && (upd_kind == kind_cond))
    begin
      lht[upd_idx] <= {upd_taken, upd_hist[`HIST_BITS-1:1]};  // newest outcome on top
      if (upd_taken && (upd_ctr != 2'b11))
        pht[upd_hist] <= upd_ctr + 2'b01;
      else if (!upd_taken && (upd_ctr != 2'b00))
        pht[upd_hist] <= upd_ctr - 2'b01;
    end
  end

endmodule

// ==== design/fetch_pc_control.sv ====
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module fetch_pc_control
  import bpu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] inst_word,
  output logic [`XLEN-1:0] fetch_pc,
  output logic             issue_valid,
  input  logic             issue_ready,
  output issue_pkt_t       issue_pkt,
  input  logic             resolve_valid,
  input  resolve_pkt_t     resolve_pkt,
  output logic             flush,
  output logic [`XLEN-1:0] lookup_pc,
  input  lookup_t          btb_hit_target,
  input  logic             pred_taken,
  output logic             bq_push,
  output bq_entry_t        bq_entry,
  input  logic             bq_full,
  input  bq_entry_t        bq_head,
  output logic             bq_pop,
  output logic             bq_clear,
  output logic             upd_valid,
  output logic [`XLEN-1:0] upd_pc,
  output ctrl_kind_e       upd_kind
);

  ctrl_kind_e       kind;
  logic             use_target;
  logic [`XLEN-1:0] seq_pc;
  issue_pkt_t       pkt_now;
  issue_pkt_t       pkt_held;
  logic             hold;
  logic             running;
  logic             mispredict;
  logic [`XLEN-1:0] redirect_pc;
  logic             xfer;

  always_comb
  begin
    case (inst_word[6:0])
      opc_branch: kind = kind_cond;
      opc_jal:    kind = kind_jal;
      opc_jalr:   kind = kind_jalr;
      default:    kind = kind_none;
    endcase
  end

  // a taken guess needs a target from the btb
  always_comb
  begin
    case (kind)
      kind_cond:          use_target = btb_hit_target.hit && pred_taken;
      kind_jal, kind_jalr: use_target = btb_hit_target.hit;
      default:            use_target = 1'b0;
    endcase
  end

  assign seq_pc    = fetch_pc + `XLEN'(4);
  assign lookup_pc = fetch_pc;

  assign pkt_now.pc         = fetch_pc;
  assign pkt_now.inst       = inst_word;
  assign pkt_now.kind       = kind;
  assign pkt_now.pred_taken = use_target;
  assign pkt_now.pred_next  = use_target ? btb_hit_target.target : seq_pc;

  // table writes during a stall must not disturb the offered packet
  assign issue_pkt = hold ? pkt_held : pkt_now;

  assign mispredict = resolve_valid &&
                      ((resolve_pkt.taken != bq_head.pred_taken) ||
                       (resolve_pkt.taken && (resolve_pkt.target != bq_head.pred_next)));
  assign redirect_pc = resolve_pkt.taken ? resolve_pkt.target : bq_head.pc + `XLEN'(4);

  assign issue_valid = running && !mispredict &&
                       !((issue_pkt.kind != kind_none) && bq_full);
  assign xfer        = issue_valid && issue_ready;

  assign bq_push             = xfer && (issue_pkt.kind != kind_none);
  assign bq_entry.pc         = issue_pkt.pc;
  assign bq_entry.kind       = issue_pkt.kind;
  assign bq_entry.pred_taken = issue_pkt.pred_taken;
  assign bq_entry.pred_next  = issue_pkt.pred_next;
  assign bq_pop              = resolve_valid;
  assign bq_clear            = mispredict;  // wins over pop in the queue

  assign upd_valid = resolve_valid;
  assign upd_pc    = bq_head.pc;
  assign upd_kind  = bq_head.kind;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      fetch_pc <= `RESET_PC;
      running  <= 1'b0;
      hold     <= 1'b0;
      flush    <= 1'b0;
    end
    else
    begin
      running <= 1'b1;
      flush   <= mispredict;
      if (mispredict)
      begin
        fetch_pc <= redirect_pc;
        hold     <= 1'b0;
      end
      else if (xfer)
      begin
        fetch_pc <= issue_pkt.pred_next;
        hold     <= 1'b0;
      end
      else if (issue_valid)
        hold <= 1'b1;  // stalled by downstream
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue_valid && !hold)
      pkt_held <= pkt_now;
  end

  // offered packet and fetch address stay put until taken or squashed
  assert property (@(posedge clk) disable iff (rst)
    issue_valid && !issue_ready |=>
      !issue_valid || ($stable(issue_pkt) && $stable(fetch_pc)));

endmodule

// ==== design/bpu_top.sv ====
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_top
  import bpu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  output logic [`XLEN-1:0] fetch_pc,
  input  logic [`XLEN-1:0] inst_word,
  output logic             issue_valid,
  input  logic             issue_ready,
  output issue_pkt_t       issue_pkt,
  input  logic             resolve_valid,
  input  resolve_pkt_t     resolve_pkt,
  output logic             flush
);

  logic [`XLEN-1:0] lookup_pc;
  lookup_t          btb_result;
  logic             bp_taken;
  logic             bq_push;
  bq_entry_t        bq_entry;
  logic             bq_full;
  bq_entry_t        bq_head;
  logic             bq_pop;
  logic             bq_clear;
  logic             upd_valid;
  logic [`XLEN-1:0] upd_pc;
  ctrl_kind_e       upd_kind;

  fetch_pc_control fetch_pc_control_i (
    .clk            (clk),
    .rst            (rst),
    .inst_word      (inst_word),
    .fetch_pc       (fetch_pc),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_pkt      (issue_pkt),
    .resolve_valid  (resolve_valid),
    .resolve_pkt    (resolve_pkt),
    .flush          (flush),
    .lookup_pc      (lookup_pc),
    .btb_hit_target (btb_result),
    .pred_taken     (bp_taken),
    .bq_push        (bq_push),
    .bq_entry       (bq_entry),
    .bq_full        (bq_full),
    .bq_head        (bq_head),
    .bq_pop         (bq_pop),
    .bq_clear       (bq_clear),
    .upd_valid      (upd_valid),
    .upd_pc         (upd_pc),
    .upd_kind       (upd_kind)
  );

  branch_queue branch_queue_i (
    .clk   (clk),
    .rst   (rst),
    .push  (bq_push),
    .entry (bq_entry),
    .pop   (bq_pop),
    .clear (bq_clear),
    .full  (bq_full),
    .empty (),          // emptiness is only checked inside the queue
    .head  (bq_head)
  );

  branch_target_buffer branch_target_buffer_i (
    .clk       (clk),
    .rst       (rst),
    .lookup_pc (lookup_pc),
    .result    (btb_result),
    .upd_valid (upd_valid),
    .upd_pc    (upd_pc),
    .upd_kind  (upd_kind),
    .resolve   (resolve_pkt)
  );

  local_history_predictor local_history_predictor_i (
    .clk        (clk),
    .rst        (rst),
    .lookup_pc  (lookup_pc),
    .pred_taken (bp_taken),
    .upd_valid  (upd_valid),
    .upd_pc     (upd_pc),
    .upd_kind   (upd_kind),
    .upd_taken  (resolve_pkt.taken)
  );

endmodule

// ==== tb/bpu_checker.sv ====
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_checker
  import bpu_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] fetch_pc,
  input  logic [`XLEN-1:0] inst_word,
  input  logic             issue_valid,
  input  logic             issue_ready,
  input  issue_pkt_t       issue_pkt,
  input  logic             resolve_valid,
  input  resolve_pkt_t     resolve_pkt,
  input  logic             flush,
  output int               value_errs,
  output int               other_errs
);

  localparam int BTB_ENTRIES = 1 << `BTB_INDEX_BITS;
  localparam int LHT_ENTRIES = 1 << `LHT_INDEX_BITS;
  localparam int PHT_ENTRIES = 1 << `HIST_BITS;

  typedef struct packed
  {
    ctrl_kind_e       kind;
    logic             taken;
    logic [`XLEN-1:0] next;
  } pred_t;

  logic [BTB_ENTRIES-1:0]   btb_vld;
  logic [`BTB_TAG_BITS-1:0] btb_tag [BTB_ENTRIES];
  logic [`XLEN-1:0]         btb_tgt [BTB_ENTRIES];
  logic [`HIST_BITS-1:0]    lht [LHT_ENTRIES];
  logic [1:0]               pht [PHT_ENTRIES];
  bq_entry_t                rec [$];       // control instructions in flight
  logic                     exp_flush = 1'b0;
  logic [`XLEN-1:0]         exp_pc;        // fetch address due next cycle
  logic                     stalled = 1'b0;
  issue_pkt_t               held_pkt;
  int                       n_value = 0;
  int                       n_other = 0;

  assign value_errs = n_value;
  assign other_errs = n_other;

  task automatic value_mismatch(input string name, input logic [127:0] want,
                                input logic [127:0] got);
    n_value++;
    $display("[FAIL] %0d ns: %s expected %0h, got %0h", $time, name, want, got);
  endtask

  task automatic protocol_error(input string what);
    n_other++;
    $display("error at %0d ns: %s", $time, what);
  endtask

  function automatic ctrl_kind_e classify(input logic [`XLEN-1:0] inst);
    case (inst[6:0])
      `OPC_BRANCH: return kind_cond;
      `OPC_JAL:    return kind_jal;
      `OPC_JALR:   return kind_jalr;
      default:     return kind_none;
    endcase
  endfunction

  // expected prediction for an instruction offered at pc
  function automatic pred_t predict(input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] inst);
    logic [`BTB_INDEX_BITS-1:0] bi;
    logic                       hit;
    logic                       dir;
    pred_t                      p;
    bi      = pc[`BTB_INDEX_BITS+1:2];
    hit     = btb_vld[bi] && (btb_tag[bi] == pc[`XLEN-1:`BTB_INDEX_BITS+2]);
    dir     = pht[lht[pc[`LHT_INDEX_BITS+1:2]]][1];
    p.kind  = classify(inst);
    p.taken = (p.kind == kind_cond) ? (hit && dir) : ((p.kind != kind_none) && hit);
    p.next  = p.taken ? btb_tgt[bi] : pc + `XLEN'(4);
    return p;
  endfunction

  task automatic train(input bq_entry_t e, input resolve_pkt_t r);
    logic [`BTB_INDEX_BITS-1:0] bi;
    logic [`LHT_INDEX_BITS-1:0] li;
    logic [`HIST_BITS-1:0]      h;
    bi = e.pc[`BTB_INDEX_BITS+1:2];
    li = e.pc[`LHT_INDEX_BITS+1:2];
    h  = lht[li];
    if ((e.kind != kind_none) && r.taken)
    begin
      btb_vld[bi] = 1'b1;
      btb_tag[bi] = e.pc[`XLEN-1:`BTB_INDEX_BITS+2];
      btb_tgt[bi] = r.target;
    end
    if (e.kind == kind_cond)
    begin
      if (r.taken && (pht[h] != 2'b11))
        pht[h] = pht[h] + 2'b01;
      else if (!r.taken && (pht[h] != 2'b00))
        pht[h] = pht[h] - 2'b01;
      lht[li] = {r.taken, h[`HIST_BITS-1:1]};  // newest outcome on top
    end
  endtask

  always @(posedge clk)
  begin
    pred_t     want;
    bq_entry_t head;
    bq_entry_t entry;
    logic      mis;
    int        depth;
    mis   = 1'b0;
    depth = rec.size();
    if (rst)
    begin
      btb_vld = '0;
      for (int i = 0; i < LHT_ENTRIES; i++)
        lht[i] = '0;
      for (int j = 0; j < PHT_ENTRIES; j++)
        pht[j] = 2'b00;
      rec.delete();
      stalled = 1'b0;
      exp_pc  = `RESET_PC;
      if (fetch_pc !== `RESET_PC)
        value_mismatch("fetch_pc", 128'(`RESET_PC), 128'(fetch_pc));
      if (issue_valid !== 1'b0)
        value_mismatch("issue_valid", 128'(0), 128'(issue_valid));
      if (flush !== 1'b0)
        value_mismatch("flush", 128'(0), 128'(flush));
    end
    else
    begin
      if (flush !== exp_flush)
        value_mismatch("flush", 128'(exp_flush), 128'(flush));
      if (fetch_pc !== exp_pc)
        value_mismatch("fetch_pc", 128'(exp_pc), 128'(fetch_pc));
      if (issue_valid && stalled)
      begin
        if (issue_pkt !== held_pkt)
          value_mismatch("issue_pkt", 128'(held_pkt), 128'(issue_pkt));
      end
      else if (issue_valid)
      begin
        want = predict(fetch_pc, inst_word);
        if (issue_pkt.pc !== fetch_pc)
          value_mismatch("issue_pkt.pc", 128'(fetch_pc), 128'(issue_pkt.pc));
        if (issue_pkt.inst !== inst_word)
          value_mismatch("issue_pkt.inst", 128'(inst_word), 128'(issue_pkt.inst));
        if (issue_pkt.kind !== want.kind)
          value_mismatch("issue_pkt.kind", 128'(want.kind), 128'(issue_pkt.kind));
        if (issue_pkt.pred_taken !== want.taken)
          value_mismatch("issue_pkt.pred_taken", 128'(want.taken), 128'(issue_pkt.pred_taken));
        if (issue_pkt.pred_next !== want.next)
          value_mismatch("issue_pkt.pred_next", 128'(want.next), 128'(issue_pkt.pred_next));
      end
      if (issue_valid && (depth >= `BQ_DEPTH) && (classify(inst_word) != kind_none))
        protocol_error("a control instruction was offered while the queue was full");
      if (resolve_valid)
      begin
        if (depth == 0)
          protocol_error("a resolve arrived with no control instruction in flight");
        else
        begin
          head = rec.pop_front();
          mis  = (resolve_pkt.taken != head.pred_taken) ||
                 (resolve_pkt.taken && (resolve_pkt.target != head.pred_next));
          train(head, resolve_pkt);
          if (mis)
            rec.delete();
        end
      end
      if (issue_valid && mis)
        protocol_error("issue_valid was high in a mispredict cycle");
      if (issue_valid && issue_ready && (issue_pkt.kind != kind_none))
      begin
        entry.pc         = issue_pkt.pc;
        entry.kind       = issue_pkt.kind;
        entry.pred_taken = issue_pkt.pred_taken;
        entry.pred_next  = issue_pkt.pred_next;
        rec.push_back(entry);
      end
      if (mis)
        exp_pc = resolve_pkt.taken ? resolve_pkt.target : head.pc + `XLEN'(4);
      else if (issue_valid && issue_ready)
        exp_pc = stalled ? held_pkt.pred_next : want.next;
      else
        exp_pc = fetch_pc;  // nothing taken, address holds
      if (!stalled)
        held_pkt = issue_pkt;  // copy from the first cycle of a stall
      stalled = issue_valid && !issue_ready;
    end
    exp_flush = mis;
  end

endmodule

// ==== tb/bpu_tb.sv ====
`timescale 1ns/1ps
`include "bpu_cfg.svh"

module bpu_tb
  import bpu_pkg::*;
();

  localparam int HALF_PERIOD = 2;
  localparam int MEM_AW      = 7;
  localparam int MEM_WORDS   = 1 << MEM_AW;
  localparam int NUM_ISSUES  = 2000;
  localparam int MAX_DELAY   = 32;
  // each issue may wait out one slow resolve, doubled for ready stalls
  localparam int TIMEOUT_NS  = NUM_ISSUES * (MAX_DELAY + 4) * 2 * (2 * HALF_PERIOD) + 1000;

  logic             clk = 1'b0;
  logic             rst;
  logic [`XLEN-1:0] fetch_pc;
  logic [`XLEN-1:0] inst_word;
  logic             issue_valid;
  logic             issue_ready;
  issue_pkt_t       issue_pkt;
  logic             resolve_valid;
  resolve_pkt_t     resolve_pkt;
  logic             flush;
  int               value_errs;
  int               other_errs;

  logic [`XLEN-1:0] prog    [MEM_WORDS];
  logic [`XLEN-1:0] tgt_tab [MEM_WORDS];  // actual target per pc
  logic [3:0]       pat_tab [MEM_WORDS];  // outcome sequence of a branch
  logic [1:0]       visits  [MEM_WORDS];
  issue_pkt_t       pend [$];             // issued control, not yet resolved
  int               delay  = 0;
  int               issued = 0;

  always #HALF_PERIOD clk = ~clk;

  assign inst_word = prog[fetch_pc[MEM_AW+1:2]];

  bpu_top bpu_top_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_pc      (fetch_pc),
    .inst_word     (inst_word),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue_pkt     (issue_pkt),
    .resolve_valid (resolve_valid),
    .resolve_pkt   (resolve_pkt),
    .flush         (flush)
  );

  bpu_checker bpu_checker_i (
    .clk           (clk),
    .rst           (rst),
    .fetch_pc      (fetch_pc),
    .inst_word     (inst_word),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue_pkt     (issue_pkt),
    .resolve_valid (resolve_valid),
    .resolve_pkt   (resolve_pkt),
    .flush         (flush),
    .value_errs    (value_errs),
    .other_errs    (other_errs)
  );

  task automatic load_program();
    int unsigned pick;
    logic [6:0]  opc;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      pick = $urandom_range(9, 0);
      if (pick < 5)
        opc = 7'b0110011;  // register alu op
      else if (pick < 7)
        opc = `OPC_BRANCH;
      else if (pick < 8)
        opc = `OPC_JAL;
      else if (pick < 9)
        opc = `OPC_JALR;
      else
        opc = `OPC_BRANCH;
      prog[i]    = {(`XLEN-7)'($urandom()), opc};
      tgt_tab[i] = `XLEN'($urandom_range(MEM_WORDS - 1, 0)) << 2;
      pat_tab[i] = 4'($urandom());
      visits[i]  = 2'd0;
    end
    prog[MEM_WORDS-1]    = {(`XLEN-7)'(0), `OPC_JAL};  // back to the start
    tgt_tab[MEM_WORDS-1] = `RESET_PC;
  endtask

  // execute model and issue consumer
  always @(posedge clk)
  begin
    issue_pkt_t        oldest;
    logic [MEM_AW-1:0] idx;
    if (!rst)
    begin
      if (resolve_valid)
        void'(pend.pop_front());
      if (flush)
        pend.delete();  // squashed by the mispredict
      if (issue_valid && issue_ready)
      begin
        issued++;
        if (issue_pkt.kind != kind_none)
          pend.push_back(issue_pkt);
      end
    end
    #1;
    issue_ready   = ($urandom_range(3, 0) != 0);
    resolve_valid = 1'b0;
    if (!rst && !flush && (pend.size() > 0))
    begin
      if (delay > 0)
        delay--;
      else
      begin
        oldest             = pend[0];
        idx                = oldest.pc[MEM_AW+1:2];
        resolve_pkt.target = tgt_tab[idx];
        if (oldest.kind == kind_cond)
        begin
          resolve_pkt.taken = pat_tab[idx][visits[idx]];
          visits[idx]       = visits[idx] + 2'd1;
        end
        else
          resolve_pkt.taken = 1'b1;
        resolve_valid = 1'b1;
        delay         = $urandom_range(MAX_DELAY, 0);
      end
    end
  end

  initial
  begin
    void'($urandom(32'hf72d_7645));
    rst           = 1'b1;
    issue_ready   = 1'b0;
    resolve_valid = 1'b0;
    resolve_pkt   = '0;
    load_program();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    wait (issued >= NUM_ISSUES);
    repeat (4) @(posedge clk);
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0))
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: only %0d of %0d packets issued", issued, NUM_ISSUES);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
design/bpu_pkg.sv
design/branch_queue.sv
design/branch_target_buffer.sv
design/local_history_predictor.sv
design/fetch_pc_control.sv
design/bpu_top.sv
tb/bpu_checker.sv
tb/bpu_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module bpu_tb -o bpu_sim

out=$(./obj_dir/bpu_sim || true)
echo "$out"
echo "$out" | grep -qx "Test passed"
